/* verilog/gpfc_pkg.sv */
package gpfc_pkg;

    ///////////////////////////////////////////////////////////////////////
    // switch and frame dimensions
    ///////////////////////////////////////////////////////////////////////

    // four network ports plus the cpu port
    localparam int PORT_NUM         = 5;
    localparam int TC_NUM           = 8;
    localparam int BEAT_WIDTH       = 256;
    localparam int PAUSE_TIME_WIDTH = 16;
    localparam int PAUSE_RANK_WIDTH = 16;
    localparam int PORT_IDX_WIDTH   = 3;

    // mac control ethertype and the gpfc opcode we accept
    localparam logic [15:0] ETHER_TYPE_PAUSE = 16'h8808;
    localparam logic [15:0] GPFC_OPCODE      = 16'h0101;

    ///////////////////////////////////////////////////////////////////////
    // pause frame beats
    ///////////////////////////////////////////////////////////////////////

    // first beat of a frame
    typedef struct packed {
        logic [47:0]        dmac;
        logic [47:0]        smac;
        logic [15:0]        ether_type;
        logic [15:0]        opcode;
        logic [TC_NUM-1:0]  class_vector;
        logic [119:0]       reserved;
    } pf_head_t;

    // second beat, times first then ranks
    typedef struct packed {
        logic [TC_NUM-1:0][PAUSE_TIME_WIDTH-1:0] pause_time;
        logic [TC_NUM-1:0][PAUSE_RANK_WIDTH-1:0] pause_rank;
    } pf_body_t;

    // the same data word, read by beat position
    typedef union packed {
        pf_head_t head;
        pf_body_t body;
    } pf_beat_u;

    ///////////////////////////////////////////////////////////////////////
    // internal transfers and status
    ///////////////////////////////////////////////////////////////////////

    // one decoded pause command
    typedef struct packed {
        logic [PORT_IDX_WIDTH-1:0]               port;
        logic [TC_NUM-1:0]                       class_vector;
        logic [TC_NUM-1:0][PAUSE_TIME_WIDTH-1:0] pause_time;
        logic [TC_NUM-1:0][PAUSE_RANK_WIDTH-1:0] pause_rank;
    } pause_cmd_t;

    // wishbone master to slave
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [BEAT_WIDTH-1:0] dat;
    } wb_m2s_t;

    // pause state of one port
    typedef struct packed {
        logic [TC_NUM-1:0]                       pause_vector;
        logic [TC_NUM-1:0][PAUSE_RANK_WIDTH-1:0] pause_rank;
    } port_pause_t;

endpackage

/* verilog/gpfc_frame_rx.sv */
`timescale 1ns/1ps

module gpfc_frame_rx
    import gpfc_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  wb_m2s_t    wb_in,
    input  logic [7:0] ingress_port,
    output logic       wb_ack,
    input  logic       full,
    output logic       push,
    output pause_cmd_t cmd
);

    localparam logic ST_HEAD = 1'b0;
    localparam logic ST_BODY = 1'b1;

    logic                      state;
    pf_beat_u                  beat;
    pf_head_t                  head_q;
    logic                      beat_req;
    logic                      accept;
    logic                      frame_ok;
    logic [PORT_IDX_WIDTH-1:0] port_idx;

    // one data word, viewed as header or body by state
    assign beat = wb_in.dat;

    // ack is registered, so a beat is not taken again while ack is out
    assign beat_req = wb_in.cyc & wb_in.stb & wb_in.we & ~wb_ack;

    // body beat waits while the command buffer is full
    assign accept = beat_req & ((state == ST_HEAD) | ~full);

    assign frame_ok = (head_q.ether_type == ETHER_TYPE_PAUSE) &&
                      (head_q.opcode == GPFC_OPCODE);

    ///////////////////////////////////////////////////////////////////////
    // ingress port decode
    ///////////////////////////////////////////////////////////////////////

    // network ports sit on the even bits, anything else is the cpu
    always_comb
    begin
        case (ingress_port)
            8'b0000_0001:
                port_idx = PORT_IDX_WIDTH'(0);
            8'b0000_0100:
                port_idx = PORT_IDX_WIDTH'(1);
            8'b0001_0000:
                port_idx = PORT_IDX_WIDTH'(2);
            8'b0100_0000:
                port_idx = PORT_IDX_WIDTH'(3);
            default:
                port_idx = PORT_IDX_WIDTH'(4);
        endcase
    end

    ///////////////////////////////////////////////////////////////////////
    // beat FSM and handshake
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            state  <= ST_HEAD;
            wb_ack <= 1'b0;
            push   <= 1'b0;
        end
        else
        begin
            wb_ack <= accept;
            // bad type or opcode is acked but never queued
            push   <= accept & (state == ST_BODY) & frame_ok;
            if (accept)
            begin
                state <= ~state;
            end
            else if (!wb_in.cyc)
            begin
                // aborted cycle, next beat is a header again
                state <= ST_HEAD;
            end
        end
    end

    // header and command registers
    always_ff @(posedge clk)
    begin
        if (accept && state == ST_HEAD)
        begin
            head_q <= beat.head;
        end
        if (accept && state == ST_BODY)
        begin
            cmd.port         <= port_idx;
            cmd.class_vector <= head_q.class_vector;
            cmd.pause_time   <= beat.body.pause_time;
            cmd.pause_rank   <= beat.body.pause_rank;
        end
    end

endmodule

/* verilog/gpfc_cmd_fifo.sv */
`timescale 1ns/1ps

module gpfc_cmd_fifo
    import gpfc_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
)
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       push,
    input  pause_cmd_t cmd,
    output logic       full,
    input  logic       pop,
    output pause_cmd_t head,
    output logic       empty
);

    localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

    pause_cmd_t            mem [FIFO_DEPTH];
    logic [ADDR_WIDTH-1:0] wr_ptr;
    logic [ADDR_WIDTH-1:0] rd_ptr;
    // one extra bit so a full buffer is told apart from an empty one
    logic [ADDR_WIDTH:0]   count;
    logic                  do_push;
    logic                  do_pop;

    assign full  = (count == (ADDR_WIDTH+1)'(FIFO_DEPTH));
    assign empty = (count == '0);

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // oldest command is always visible
    assign head = mem[rd_ptr];

    ///////////////////////////////////////////////////////////////////////
    // pointers and occupancy
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (do_push && !do_pop)
            begin
                count <= count + 1'b1;
            end
            else if (do_pop && !do_push)
            begin
                count <= count - 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= cmd;
        end
    end

endmodule

/* verilog/gpfc_pause_table.sv */
`timescale 1ns/1ps

module gpfc_pause_table
    import gpfc_pkg::*;
(
    input  logic                       clk,
    input  logic                       rstn,
    input  pause_cmd_t                 head,
    input  logic                       empty,
    output logic                       pop,
    output port_pause_t [PORT_NUM-1:0] pause_status
);

    localparam int TC_IDX_WIDTH = $clog2(TC_NUM);

    // frame quantum is 64 bytes, one cycle moves 32, hence one extra bit
    logic [PAUSE_TIME_WIDTH:0]   timer [PORT_NUM][TC_NUM];
    logic [PAUSE_RANK_WIDTH-1:0] rank  [PORT_NUM][TC_NUM];

    logic [TC_NUM-1:0]       done_mask;
    logic [TC_NUM-1:0]       pending;
    logic [TC_NUM-1:0]       cur_onehot;
    logic [TC_NUM-1:0]       remaining;
    logic [TC_IDX_WIDTH-1:0] cur_tc;
    logic                    wr_en;

    ///////////////////////////////////////////////////////////////////////
    // class cursor over the head command
    ///////////////////////////////////////////////////////////////////////

    // classes of the head command not yet written
    assign pending = empty ? '0 : (head.class_vector & ~done_mask);

    // lowest pending class goes first
    always_comb
    begin
        cur_tc = '0;
        for (int i = TC_NUM - 1; i >= 0; i--)
        begin
            if (pending[i])
            begin
                cur_tc = TC_IDX_WIDTH'(i);
            end
        end
    end

    assign cur_onehot = TC_NUM'(1) << cur_tc;
    assign remaining  = pending & ~cur_onehot;
    assign wr_en      = |pending;

    // an empty vector still spends its one cycle at the head
    assign pop = ~empty & (remaining == '0);

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            done_mask <= '0;
        end
        else if (pop)
        begin
            done_mask <= '0;
        end
        else if (wr_en)
        begin
            done_mask <= done_mask | cur_onehot;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // timers and ranks
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            for (int p = 0; p < PORT_NUM; p++)
            begin
                for (int t = 0; t < TC_NUM; t++)
                begin
                    timer[p][t] <= '0;
                    rank[p][t]  <= '0;
                end
            end
        end
        else
        begin
            for (int p = 0; p < PORT_NUM; p++)
            begin
                for (int t = 0; t < TC_NUM; t++)
                begin
                    if (wr_en && head.port == p && cur_tc == t)
                    begin
                        timer[p][t] <= {head.pause_time[t], 1'b0};
                        // time zero releases the class right away
                        rank[p][t]  <= (head.pause_time[t] == '0) ? '0 : head.pause_rank[t];
                    end
                    else if (timer[p][t] != '0)
                    begin
                        // counts down and holds at zero
                        timer[p][t] <= timer[p][t] - 1'b1;
                        if (timer[p][t] == (PAUSE_TIME_WIDTH+1)'(1))
                        begin
                            rank[p][t] <= '0;
                        end
                    end
                end
            end
        end
    end

    // status view, a class is paused while its timer runs
    always_comb
    begin
        for (int p = 0; p < PORT_NUM; p++)
        begin
            for (int t = 0; t < TC_NUM; t++)
            begin
                pause_status[p].pause_vector[t] = (timer[p][t] != '0);
                pause_status[p].pause_rank[t]   = rank[p][t];
            end
        end
    end

endmodule

/* verilog/gpfc_agent.sv */
`timescale 1ns/1ps

module gpfc_agent
    import gpfc_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
)
(
    input  logic                       clk,
    input  logic                       rstn,
    input  wb_m2s_t                    wb_in,
    input  logic [7:0]                 ingress_port,
    output logic                       wb_ack,
    output port_pause_t [PORT_NUM-1:0] pause_status
);

    // receiver to buffer
    logic       push;
    logic       full;
    pause_cmd_t cmd;

    // buffer to pause table
    logic       pop;
    logic       empty;
    pause_cmd_t head;

    gpfc_frame_rx u_frame_rx (
        .clk          (clk),
        .rstn         (rstn),
        .wb_in        (wb_in),
        .ingress_port (ingress_port),
        .wb_ack       (wb_ack),
        .full         (full),
        .push         (push),
        .cmd          (cmd)
    );

    gpfc_cmd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_cmd_fifo (
        .clk   (clk),
        .rstn  (rstn),
        .push  (push),
        .cmd   (cmd),
        .full  (full),
        .pop   (pop),
        .head  (head),
        .empty (empty)
    );

    gpfc_pause_table u_pause_table (
        .clk          (clk),
        .rstn         (rstn),
        .head         (head),
        .empty        (empty),
        .pop          (pop),
        .pause_status (pause_status)
    );

endmodule

/* dv/gpfc_agent_asserts.sv */
`timescale 1ns/1ps

module gpfc_agent_asserts
    import gpfc_pkg::*;
(
    input logic                       clk,
    input logic                       rstn,
    input wb_m2s_t                    wb_in,
    input logic                       wb_ack,
    input port_pause_t [PORT_NUM-1:0] pause_status
);

    // number of assertion failures seen so far
    int fail_count = 0;

    ///////////////////////////////////////////////////////////////////////
    // wishbone handshake
    ///////////////////////////////////////////////////////////////////////

    a_ack_needs_stb: assert property (@(posedge clk) disable iff (!rstn)
        wb_ack |-> (wb_in.cyc && wb_in.stb))
    else
    begin
        fail_count++;
        $error("ack seen without cyc and stb");
    end

    a_ack_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
        wb_ack |=> !wb_ack)
    else
    begin
        fail_count++;
        $error("ack high in two consecutive cycles");
    end

    // reset clears handshake and the whole table
    a_reset_clear: assert property (@(posedge clk)
        !rstn |=> (!wb_ack && pause_status == '0))
    else
    begin
        fail_count++;
        $error("state not cleared by reset");
    end

    ///////////////////////////////////////////////////////////////////////
    // pause status
    ///////////////////////////////////////////////////////////////////////

    // a released class never shows a rank
    for (genvar p = 0; p < PORT_NUM; p++)
    begin : g_port
        for (genvar t = 0; t < TC_NUM; t++)
        begin : g_tc
            a_rank_zero: assert property (@(posedge clk) disable iff (!rstn)
                !pause_status[p].pause_vector[t] |-> pause_status[p].pause_rank[t] == '0)
            else
            begin
                fail_count++;
                $error("rank nonzero on a released class");
            end
        end
    end

endmodule

bind gpfc_agent gpfc_agent_asserts u_asserts (
    .clk          (clk),
    .rstn         (rstn),
    .wb_in        (wb_in),
    .wb_ack       (wb_ack),
    .pause_status (pause_status)
);

/* dv/gpfc_agent_tb.sv */
`timescale 1ns/1ps

module gpfc_agent_tb
    import gpfc_pkg::*;
;

    logic                       clk;
    logic                       rstn;
    wb_m2s_t                    wb_in;
    logic [7:0]                 ingress_port;
    logic                       wb_ack;
    port_pause_t [PORT_NUM-1:0] status;

    logic [15:0] lfsr = 16'd71;
    int          max_body_wait;

    gpfc_agent #(
        .FIFO_DEPTH (4)
    ) uut (
        .clk          (clk),
        .rstn         (rstn),
        .wb_in        (wb_in),
        .ingress_port (ingress_port),
        .wb_ack       (wb_ack),
        .pause_status (status)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #50 clk = ~clk;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // helpers
    ///////////////////////////////////////////////////////////////////////

    // fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual)
        else
        begin
            $display("FAILED %s expected %0d actual %0d", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timed out waiting for %s", what);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    // one beat, held until the slave acks
    task automatic send_beat(input logic [BEAT_WIDTH-1:0] data, output int waited);
        wb_in.cyc = 1'b1;
        wb_in.stb = 1'b1;
        wb_in.we  = 1'b1;
        wb_in.dat = data;
        waited    = 0;
        do
        begin
            next_cycle();
            waited++;
            if (waited > 200)
            begin
                timeout_fail("wishbone ack");
            end
        end
        while (!wb_ack);
        // registered ack is taken at the next edge, strobe stays up until then
        next_cycle();
        wb_in.stb = 1'b0;
    endtask

    task automatic send_frame(input pf_head_t h, input pf_body_t b, input logic [7:0] port);
        int waited;
        send_beat(h, waited);
        ingress_port = port;
        send_beat(b, waited);
        if (waited > max_body_wait)
        begin
            max_body_wait = waited;
        end
        wb_in.cyc = 1'b0;
    endtask

    task automatic random_frame(output pf_head_t h, output pf_body_t b);
        h              = '0;
        h.dmac         = 48'h0180_c200_0001;
        h.smac         = 48'h0200_0000_0010;
        h.ether_type   = 16'h8808;
        h.opcode       = 16'h0101;
        // class 0 is always set and is the one followed
        h.class_vector = rand_bits(8) | 8'h01;
        for (int t = 0; t < TC_NUM; t++)
        begin
            b.pause_time[t] = rand_bits(6) % 40 + 1;
            b.pause_rank[t] = rand_bits(16);
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (status != '0)
        begin
            next_cycle();
            n++;
            if (n > 2000)
            begin
                timeout_fail("all classes to be released");
            end
        end
    endtask

    task automatic wait_pause(input int port, input int tc, input logic level,
                              input int limit);
        int n;
        n = 0;
        while (status[port].pause_vector[tc] != level)
        begin
            next_cycle();
            n++;
            if (n > limit)
            begin
                timeout_fail("a pause bit to change");
            end
        end
    endtask

    // a dropped frame must leave the table idle
    task automatic expect_no_pause(input string name);
        repeat (30)
        begin
            next_cycle();
            check_value(name, 0, (status != '0));
        end
    endtask

    ///////////////////////////////////////////////////////////////////////
    // tests
    ///////////////////////////////////////////////////////////////////////

    // set, port decode and expiry of class 0
    task automatic pause_and_expire(input logic [7:0] port, input int exp_port);
        pf_head_t h;
        pf_body_t b;
        int       high;
        wait_idle();
        random_frame(h, b);
        send_frame(h, b, port);
        wait_pause(exp_port, 0, 1'b1, 200);
        check_value("pause_rank", b.pause_rank[0], status[exp_port].pause_rank[0]);
        for (int p = 0; p < PORT_NUM; p++)
        begin
            if (p != exp_port)
            begin
                check_value("other_port", 0, status[p].pause_vector);
            end
        end
        high = 0;
        while (status[exp_port].pause_vector[0])
        begin
            high++;
            next_cycle();
            if (high > 200)
            begin
                timeout_fail("a pause bit to expire");
            end
        end
        check_value("pause_length", 2 * b.pause_time[0], high);
        check_value("rank_at_expiry", 0, status[exp_port].pause_rank[0]);
    endtask

    task automatic bad_frames();
        pf_head_t h;
        pf_body_t b;
        wait_idle();
        random_frame(h, b);
        h.ether_type = 16'h88a8;
        send_frame(h, b, 8'h04);
        expect_no_pause("bad_type");
        random_frame(h, b);
        h.opcode = 16'h0001;
        send_frame(h, b, 8'h10);
        expect_no_pause("bad_opcode");
    endtask

    task automatic zero_release();
        pf_head_t h;
        pf_body_t b;
        random_frame(h, b);
        h.class_vector = 8'h03;
        b.pause_time[0] = 16'd40;
        b.pause_time[1] = 16'd40;
        wait_idle();
        send_frame(h, b, 8'h01);
        wait_pause(0, 0, 1'b1, 200);
        wait_pause(0, 1, 1'b1, 200);
        h.class_vector = 8'h01;
        b.pause_time[0] = 16'd0;
        send_frame(h, b, 8'h01);
        // release comes right after the frame, long before the timer would run out
        wait_pause(0, 0, 1'b0, 20);
        check_value("released_rank", 0, status[0].pause_rank[0]);
        check_value("kept_class", 1, status[0].pause_vector[1]);
        check_value("kept_rank", b.pause_rank[1], status[0].pause_rank[1]);
    endtask

    // full vectors drain slower than frames arrive
    task automatic burst();
        pf_head_t h;
        pf_body_t b;
        wait_idle();
        max_body_wait = 0;
        repeat (8)
        begin
            random_frame(h, b);
            h.class_vector = 8'hff;
            send_frame(h, b, 8'h02);
        end
        check_value("body_ack_delayed", 1, (max_body_wait > 1));
    endtask

    // stop at the first concurrent assertion failure
    initial
    begin
        forever
        begin
            @(negedge clk);
            if (uut.u_asserts.fail_count != 0)
            begin
                $display("concurrent assertion failed");
                $display("Simulation FAILED");
                $fatal(1);
            end
        end
    end

    initial
    begin
        rstn         = 1'b0;
        wb_in        = '0;
        ingress_port = '0;
        repeat (5)
        begin
            @(posedge clk);
        end
        #10;
        rstn = 1'b1;
        check_value("reset_status", 0, (status != '0));
        pause_and_expire(8'h01, 0);
        pause_and_expire(8'h04, 1);
        pause_and_expire(8'h10, 2);
        pause_and_expire(8'h40, 3);
        pause_and_expire(8'h08, 4);
        bad_frames();
        zero_release();
        burst();
        wait_idle();
        next_cycle();
        if (uut.u_asserts.fail_count != 0)
        begin
            $display("Simulation FAILED");
            $fatal(1);
        end
        else
        begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

/* sources.f */
verilog/gpfc_pkg.sv
verilog/gpfc_frame_rx.sv
verilog/gpfc_cmd_fifo.sv
verilog/gpfc_pause_table.sv
verilog/gpfc_agent.sv
dv/gpfc_agent_asserts.sv
dv/gpfc_agent_tb.sv

/* Bender.yml */
package:
  name: gpfc_agent

sources:
  - files:
      - verilog/gpfc_pkg.sv
      - verilog/gpfc_frame_rx.sv
      - verilog/gpfc_cmd_fifo.sv
      - verilog/gpfc_pause_table.sv
      - verilog/gpfc_agent.sv
  - target: test
    files:
      - dv/gpfc_agent_asserts.sv
      - dv/gpfc_agent_tb.sv
